//--- include/bpb_settings.svh
`ifndef BPB_SETTINGS_SVH
`define BPB_SETTINGS_SVH

// --------------------
// pc and table sizing
// --------------------

// fetch and commit pc width
`define BPB_PC_WIDTH 32

// index widths, pc bits 2 and up
`define BPB_ENTRY_WIDTH0 2    // table 0, 4 lines
`define BPB_ENTRY_WIDTH1 4    // table 1, 16 lines

// tag is whatever is left above the index
// tag width = BPB_PC_WIDTH - 2 - entry width

`endif

//--- source/bpb_pkg.sv
`include "bpb_settings.svh"

package bpb_pkg;

    // --------------------
    // shared types
    // --------------------

    // pc or branch target
    typedef logic [`BPB_PC_WIDTH-1:0] word_t;

    // one prediction, also the commit payload
    typedef struct packed {
        logic  taken;
        word_t destpc;
    } bpb_result_t;

endpackage

//--- source/bpb_commit_if.sv
`timescale 1ns/1ps

interface bpb_commit_if
    import bpb_pkg::*;
(
    input logic clk,
    input logic reset
);

    logic        stall;          // commits dropped while high
    logic        wen;
    word_t       pc_commit;      // pc of the resolved branch
    bpb_result_t destpc_commit;  // outcome and target

    // top drives, tables read
    modport source (output stall, wen, pc_commit, destpc_commit);
    modport sink (input stall, wen, pc_commit, destpc_commit);

    // back end must present a clean strobe and pc
    commit_known : assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown({wen, pc_commit})
    )
        else $error("bpb_commit_if: wen or pc_commit unknown");

endinterface

//--- source/bpb_line.sv
`timescale 1ns/1ps
`include "bpb_settings.svh"

module bpb_line
    import bpb_pkg::*;
#(
    parameter int ENTRY_WIDTH = `BPB_ENTRY_WIDTH0
)(
    input  logic              clk,
    input  logic              reset,
    bpb_commit_if.sink        commit,
    input  logic              sel,
    input  word_t       [1:0] pc_predict,
    output logic        [1:0] hit,
    output bpb_result_t [1:0] result
);

    localparam int TAG_WIDTH = `BPB_PC_WIDTH - 2 - ENTRY_WIDTH;

    logic                 valid;
    logic [TAG_WIDTH-1:0] tag;
    word_t                target;
    logic [1:0]           state;       // 2-bit saturating style counter

    logic [TAG_WIDTH-1:0] tag_commit;
    logic                 accept;
    logic                 insert;
    logic [1:0]           state_base;
    logic [1:0]           state_next;

    // --------------------
    // commit side
    // --------------------

    assign tag_commit = commit.pc_commit[`BPB_PC_WIDTH-1 -: TAG_WIDTH];
    assign accept     = commit.wen && !commit.stall && sel;
    assign insert     = !valid || (tag != tag_commit);

    // a fresh line starts weakly not taken, outcome applied on top
    assign state_base = insert ? 2'b01 : state;

    always_comb
    begin
        case (state_base)
            2'b00:   state_next = commit.destpc_commit.taken ? 2'b01 : 2'b00;
            2'b01:   state_next = commit.destpc_commit.taken ? 2'b11 : 2'b00;
            2'b10:   state_next = commit.destpc_commit.taken ? 2'b11 : 2'b00;
            default: state_next = commit.destpc_commit.taken ? 2'b11 : 2'b10;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid <= 1'b0;
        end
        else if (accept)
        begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            if (insert)
            begin
                tag    <= tag_commit;
                target <= commit.destpc_commit.destpc;
            end
            state <= state_next;
        end
    end

    // --------------------
    // lookup side
    // --------------------

    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            hit[s]           = valid && (tag == pc_predict[s][`BPB_PC_WIDTH-1 -: TAG_WIDTH]);
            result[s].taken  = hit[s] && state[1];  // high bit predicts taken
            result[s].destpc = target;
        end
    end

    // the committed branch owns this line from the next cycle on
    line_owned : assert property (
        @(posedge clk) disable iff (reset)
        (commit.wen && !commit.stall && sel) |=> (valid && tag == $past(tag_commit))
    )
        else $error("bpb_line: line does not hold the committed branch");

endmodule

//--- source/bpb_table.sv
`timescale 1ns/1ps
`include "bpb_settings.svh"

module bpb_table
    import bpb_pkg::*;
#(
    parameter int ENTRY_WIDTH = `BPB_ENTRY_WIDTH0
)(
    input  logic              clk,
    input  logic              reset,
    bpb_commit_if.sink        commit,
    input  word_t       [1:0] pc_predict,
    output logic        [1:0] hit,
    output bpb_result_t [1:0] result
);

    localparam int LINES = 1 << ENTRY_WIDTH;

    logic [LINES-1:0]       sel;
    logic [ENTRY_WIDTH-1:0] commit_index;
    logic [ENTRY_WIDTH-1:0] predict_index [2];

    // per line answers for both slots
    logic        [1:0] line_hit    [LINES];
    bpb_result_t [1:0] line_result [LINES];

    assign commit_index = commit.pc_commit[2 +: ENTRY_WIDTH];

    // --------------------
    // line array
    // --------------------

    generate
        for (genvar k = 0; k < LINES; k++)
        begin : g_line
            assign sel[k] = (commit_index == ENTRY_WIDTH'(k));  // index decode

            bpb_line #(
                .ENTRY_WIDTH (ENTRY_WIDTH)
            ) u_line (
                .clk        (clk),
                .reset      (reset),
                .commit     (commit),
                .sel        (sel[k]),
                .pc_predict (pc_predict),
                .hit        (line_hit[k]),
                .result     (line_result[k])
            );
        end
    endgenerate

    // --------------------
    // lookup mux
    // --------------------

    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            predict_index[s] = pc_predict[s][2 +: ENTRY_WIDTH];
            hit[s]           = line_hit[predict_index[s]][s];
            result[s]        = line_result[predict_index[s]][s];
        end
    end

    // exactly one line takes a commit
    sel_onehot : assert property (
        @(posedge clk) disable iff (reset)
        commit.wen |-> $onehot(sel)
    )
        else $error("bpb_table: line selects not one-hot");

endmodule

//--- source/bpb_select.sv
`timescale 1ns/1ps

module bpb_select
    import bpb_pkg::*;
(
    input  logic        [1:0] hit0,
    input  bpb_result_t [1:0] result0,
    input  logic        [1:0] hit1,
    input  bpb_result_t [1:0] result1,
    output logic        [1:0] hit_predict,
    output bpb_result_t [1:0] destpc_predict
);

    // --------------------
    // per slot priority
    // --------------------

    // table 1 has more lines, so it is trusted first
    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            if (hit1[s])
            begin
                hit_predict[s]    = 1'b1;
                destpc_predict[s] = result1[s];
            end
            else if (hit0[s])
            begin
                hit_predict[s]    = 1'b1;
                destpc_predict[s] = result0[s];
            end
            else
            begin
                hit_predict[s]    = 1'b0;
                destpc_predict[s] = '0;     // miss, not taken to pc 0
            end
        end
    end

    // a taken bit from any line must come with that line's hit
    always_comb
    begin
        slot0_taken_hit : assert final ((result0[0].taken !== 1'b1 || hit0[0])
                                        && (result1[0].taken !== 1'b1 || hit1[0]))
            else $error("bpb_select: slot 0 taken without hit");
        slot1_taken_hit : assert final ((result0[1].taken !== 1'b1 || hit0[1])
                                        && (result1[1].taken !== 1'b1 || hit1[1]))
            else $error("bpb_select: slot 1 taken without hit");
    end

endmodule

//--- source/bpb_top.sv
`timescale 1ns/1ps
`include "bpb_settings.svh"

module bpb_top
    import bpb_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  logic              wen,
    input  word_t       [1:0] pc_predict,
    input  word_t             pc_commit,
    input  bpb_result_t       destpc_commit,
    output logic        [1:0] hit_predict,
    output bpb_result_t [1:0] destpc_predict
);

    logic        [1:0] hit0;
    bpb_result_t [1:0] result0;
    logic        [1:0] hit1;
    bpb_result_t [1:0] result1;

    // --------------------
    // commit bundle
    // --------------------

    bpb_commit_if u_commit (
        .clk   (clk),
        .reset (reset)
    );

    assign u_commit.stall         = stall;
    assign u_commit.wen           = wen;
    assign u_commit.pc_commit     = pc_commit;
    assign u_commit.destpc_commit = destpc_commit;

    // --------------------
    // tables
    // --------------------

    // both see every lookup and every commit
    bpb_table #(
        .ENTRY_WIDTH (`BPB_ENTRY_WIDTH0)
    ) u_table0 (
        .clk        (clk),
        .reset      (reset),
        .commit     (u_commit.sink),
        .pc_predict (pc_predict),
        .hit        (hit0),
        .result     (result0)
    );

    bpb_table #(
        .ENTRY_WIDTH (`BPB_ENTRY_WIDTH1)
    ) u_table1 (
        .clk        (clk),
        .reset      (reset),
        .commit     (u_commit.sink),
        .pc_predict (pc_predict),
        .hit        (hit1),
        .result     (result1)
    );

    bpb_select u_select (
        .hit0           (hit0),
        .result0        (result0),
        .hit1           (hit1),
        .result1        (result1),
        .hit_predict    (hit_predict),
        .destpc_predict (destpc_predict)
    );

endmodule

//--- tests/bpb_tb.sv
`timescale 1ns/1ps
`include "bpb_settings.svh"

module bpb_tb
    import bpb_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 2000;   // about three times the length of all tests
    localparam int RANDOM_CYCLES  = 500;

    // counter walk, first step at index 0
    localparam bit [0:10] STEP_OUTCOME = 11'b01110100100;
    localparam bit [0:10] STEP_TAKEN   = 11'b00111110000;

    localparam word_t PC_A = 32'h0000_1000;
    localparam word_t PC_C = 32'h0000_1104;
    localparam word_t PC_D = 32'h0000_1208;
    localparam word_t PC_E = 32'h0000_200c;   // table 0 index 3, table 1 index 3
    localparam word_t PC_F = 32'h0000_201c;   // table 0 index 3, table 1 index 7

    logic              clk;
    logic              reset;
    logic              stall;
    logic              wen;
    word_t       [1:0] pc_predict;
    word_t             pc_commit;
    bpb_result_t       destpc_commit;
    logic        [1:0] hit_predict;
    bpb_result_t [1:0] destpc_predict;

    int errors;
    int test_errors_start;
    int tests_passed;
    int tests_failed;
    int cycles;

    bpb_top u_bpb_top (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .wen            (wen),
        .pc_predict     (pc_predict),
        .pc_commit      (pc_commit),
        .destpc_commit  (destpc_commit),
        .hit_predict    (hit_predict),
        .destpc_predict (destpc_predict)
    );

    always #2 clk = ~clk;

    // --------------------
    // reference model
    // --------------------

    logic       m_valid  [2][16];
    word_t      m_tag    [2][16];
    word_t      m_target [2][16];
    logic [1:0] m_state  [2][16];

    logic        [1:0] exp_hit;
    bpb_result_t [1:0] exp_result;

    function automatic int unsigned index_of(input int t, input word_t pc);
        int w;
        w = (t == 0) ? `BPB_ENTRY_WIDTH0 : `BPB_ENTRY_WIDTH1;
        return (pc >> 2) & ((1 << w) - 1);
    endfunction

    function automatic word_t tag_of(input int t, input word_t pc);
        int w;
        w = (t == 0) ? `BPB_ENTRY_WIDTH0 : `BPB_ENTRY_WIDTH1;
        return pc >> (2 + w);
    endfunction

    function automatic logic [1:0] counter_step(input logic [1:0] cur, input logic taken);
        logic [1:0] nxt;
        if (taken)
            nxt = (cur == 2'b00) ? 2'b01 : 2'b11;
        else
            nxt = (cur == 2'b11) ? 2'b10 : 2'b00;
        return nxt;
    endfunction

    always @(posedge clk)
    begin
        int unsigned k;
        logic        ins;
        if (reset)
        begin
            for (int t = 0; t < 2; t++)
                for (int j = 0; j < 16; j++)
                    m_valid[t][j] <= 1'b0;
        end
        else if (wen && !stall)
        begin
            for (int t = 0; t < 2; t++)
            begin
                k   = index_of(t, pc_commit);
                ins = !m_valid[t][k] || (m_tag[t][k] != tag_of(t, pc_commit));
                m_valid[t][k] <= 1'b1;
                if (ins)
                begin
                    m_tag[t][k]    <= tag_of(t, pc_commit);
                    m_target[t][k] <= destpc_commit.destpc;
                end
                m_state[t][k] <= counter_step(ins ? 2'b01 : m_state[t][k],
                                              destpc_commit.taken);
            end
        end
    end

    // later table overrides, so table 1 wins
    always_comb
    begin
        int unsigned k;
        for (int s = 0; s < 2; s++)
        begin
            exp_hit[s]    = 1'b0;
            exp_result[s] = '0;
            for (int t = 0; t < 2; t++)
            begin
                k = index_of(t, pc_predict[s]);
                if (m_valid[t][k] === 1'b1 && m_tag[t][k] == tag_of(t, pc_predict[s]))
                begin
                    exp_hit[s]           = 1'b1;
                    exp_result[s].taken  = m_state[t][k][1];
                    exp_result[s].destpc = m_target[t][k];
                end
            end
        end
    end

    // --------------------
    // checks
    // --------------------

    for (genvar s = 0; s < 2; s++)
    begin : g_slot_check
        slot_matches : assert property (
            @(posedge clk) disable iff (reset)
            (hit_predict[s] == exp_hit[s]) && (destpc_predict[s] == exp_result[s])
        )
        else
        begin
            $display("Error at %0d ns: slot %0d pc %h got hit %b %b/%h, model %b %b/%h",
                     $time, s, $sampled(pc_predict[s]), $sampled(hit_predict[s]),
                     $sampled(destpc_predict[s].taken), $sampled(destpc_predict[s].destpc),
                     $sampled(exp_hit[s]), $sampled(exp_result[s].taken),
                     $sampled(exp_result[s].destpc));
            errors++;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------
    // stimulus tasks
    // --------------------

    task automatic drive_commit(input word_t pc, input logic taken, input word_t target,
                                input logic hold);
        @(negedge clk);
        wen           = 1'b1;
        stall         = hold;
        pc_commit     = pc;
        destpc_commit = {taken, target};
    endtask

    // lookup in the low phase, well away from both edges
    task automatic lookup_expect(input word_t pc0, input word_t pc1, input logic [1:0] e_hit,
                                 input bpb_result_t e0, input bpb_result_t e1,
                                 input string what);
        @(negedge clk);
        wen           = 1'b0;
        stall         = 1'b0;
        pc_predict[0] = pc0;
        pc_predict[1] = pc1;
        #1;
        lookup_ok : assert (hit_predict === e_hit && destpc_predict[0] === e0
                            && destpc_predict[1] === e1)
        else
        begin
            $display("Error at %0d ns: %s, got hit %b %h %h, expected hit %b %h %h",
                     $time, what, hit_predict, destpc_predict[0], destpc_predict[1],
                     e_hit, e0, e1);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors_start)
        begin
            tests_passed++;
            $display("test %s passed", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - test_errors_start);
        end
        test_errors_start = errors;
    endtask

    task automatic random_traffic();
        word_t pool [8];
        for (int i = 0; i < 8; i++)
            pool[i] = 32'h0000_8000 | ($urandom & 32'h0000_00fc);   // small pool, heavy aliasing
        repeat (RANDOM_CYCLES)
        begin
            @(negedge clk);
            wen           = 1'($urandom);
            stall         = (($urandom % 4) == 0);
            pc_commit     = pool[$urandom % 8];
            destpc_commit = {1'($urandom), word_t'($urandom) & 32'hffff_fffc};
            pc_predict[0] = pool[$urandom % 8];
            pc_predict[1] = pool[$urandom % 8];
        end
        @(negedge clk);
        wen   = 1'b0;
        stall = 1'b0;
    endtask

    // --------------------
    // test sequence
    // --------------------

    initial
    begin
        void'($urandom(32'hf66b));
        clk               = 1'b0;
        reset             = 1'b1;
        stall             = 1'b0;
        wen               = 1'b0;
        pc_predict        = '0;
        pc_commit         = '0;
        destpc_commit     = '0;
        errors            = 0;
        test_errors_start = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        cycles            = 0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        lookup_expect(PC_A, PC_E, 2'b00, '0, '0, "lookup after reset");
        end_test("reset_miss");

        drive_commit(PC_A, 1'b1, 32'h0000_4000, 1'b0);
        lookup_expect(PC_A, PC_A, 2'b11, {1'b1, 32'h0000_4000}, {1'b1, 32'h0000_4000},
                      "taken insert");
        end_test("insert_taken");

        for (int i = 0; i < 11; i++)
        begin
            drive_commit(PC_C, STEP_OUTCOME[i], 32'h0000_5000, 1'b0);
            lookup_expect(PC_C, PC_C, 2'b11, {STEP_TAKEN[i], 32'h0000_5000},
                          {STEP_TAKEN[i], 32'h0000_5000}, $sformatf("counter step %0d", i));
        end
        end_test("counter_walk");

        drive_commit(PC_D, 1'b1, 32'h0000_6000, 1'b1);
        lookup_expect(PC_D, PC_D, 2'b00, '0, '0, "branch committed under stall");
        // two not-taken drops, a leak would pull A down to 00
        drive_commit(PC_A, 1'b0, 32'h0000_4000, 1'b1);
        drive_commit(PC_A, 1'b0, 32'h0000_4000, 1'b1);
        lookup_expect(PC_A, PC_D, 2'b01, {1'b1, 32'h0000_4000}, '0, "stalled not-taken");
        end_test("stall_drop");

        drive_commit(PC_E, 1'b1, 32'h0000_7000, 1'b0);
        drive_commit(PC_F, 1'b1, 32'h0000_7800, 1'b0);
        lookup_expect(PC_E, PC_F, 2'b11, {1'b1, 32'h0000_7000}, {1'b1, 32'h0000_7800},
                      "table 1 keeps the replaced branch");
        drive_commit(PC_E, 1'b0, 32'h0000_7000, 1'b0);
        lookup_expect(PC_E, PC_F, 2'b11, {1'b1, 32'h0000_7000}, {1'b1, 32'h0000_7800},
                      "table 1 state decides");
        end_test("replace_priority");

        random_traffic();
        end_test("random_traffic");

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
source/bpb_pkg.sv
source/bpb_commit_if.sv
source/bpb_line.sv
source/bpb_table.sv
source/bpb_select.sv
source/bpb_top.sv
tests/bpb_tb.sv

//--- Bender.yml
package:
  name: bpb

export_include_dirs:
  - include

sources:
  # design
  - include_dirs:
      - include
    files:
      - source/bpb_pkg.sv
      - source/bpb_commit_if.sv
      - source/bpb_line.sv
      - source/bpb_table.sv
      - source/bpb_select.sv
      - source/bpb_top.sv

  # testbench
  - target: test
    include_dirs:
      - include
    files:
      - tests/bpb_tb.sv
